//--- logic/exec_pkg.sv
package exec_pkg;

    localparam int XLEN     = 32;
    localparam int PC_W     = 32;
    localparam int MD_ITERS = 32;

    typedef enum logic [4:0]
    {
        OP_ADD,
        OP_SUB,
        OP_SLL,
        OP_SLT,
        OP_SLTU,
        OP_XOR,
        OP_SRL,
        OP_SRA,
        OP_OR,
        OP_AND,
        OP_MUL,
        OP_MULH,
        OP_MULHSU,
        OP_MULHU,
        OP_DIV,
        OP_DIVU,
        OP_REM,
        OP_REMU
    } exec_op_t;

    // Same encoding as the branch funct3 field.
    typedef enum logic [2:0]
    {
        BR_EQ  = 3'b000,
        BR_NE  = 3'b001,
        BR_LT  = 3'b100,
        BR_GE  = 3'b101,
        BR_LTU = 3'b110,
        BR_GEU = 3'b111
    } br_cond_t;

    typedef enum logic [1:0]
    {
        ST_BYTE = 2'b00,
        ST_HALF = 2'b01,
        ST_WORD = 2'b10
    } st_size_t;

    typedef enum logic [1:0]
    {
        ST_IDLE,
        ST_ITER,
        ST_DONE
    } exec_state_t;

endpackage

//--- logic/exec_adder.sv
`timescale 1ns/1ps

module exec_adder
(
    input  logic                    i_sub,
    input  logic [exec_pkg::XLEN:0] i_op1,
    input  logic [exec_pkg::XLEN:0] i_op2,
    output logic [exec_pkg::XLEN:0] o_sum,
    output logic                    o_eq,
    output logic                    o_lts,
    output logic                    o_ltu
);
    import exec_pkg::*;

    logic [XLEN:0] op2_eff;
    logic          sign_diff;

    // Subtraction is addition of the inverted operand with a carry in.
    assign op2_eff = i_sub ? ~i_op2 : i_op2;
    assign o_sum   = i_op1 + op2_eff + {{XLEN{1'b0}}, i_sub};

    assign sign_diff = i_op1[XLEN-1] ^ i_op2[XLEN-1];

    assign o_eq  = (o_sum == '0);
    assign o_lts = sign_diff ? i_op1[XLEN-1] : o_sum[XLEN-1]; // Differing signs decide directly.
    assign o_ltu = o_sum[XLEN];                                // Borrow out of the top bit.

endmodule

//--- logic/exec_shift_logic.sv
`timescale 1ns/1ps

module exec_shift_logic
(
    input  logic [exec_pkg::XLEN-1:0] i_op1,
    input  logic [exec_pkg::XLEN-1:0] i_op2,
    input  logic [4:0]                i_shamt,
    input  logic                      i_arith,
    output logic [exec_pkg::XLEN-1:0] o_xor,
    output logic [exec_pkg::XLEN-1:0] o_or,
    output logic [exec_pkg::XLEN-1:0] o_and,
    output logic [exec_pkg::XLEN-1:0] o_shl,
    output logic [exec_pkg::XLEN-1:0] o_shr
);
    import exec_pkg::*;

    logic [XLEN:0] shr_ext;
    logic [XLEN:0] shr_full;

    assign o_xor = i_op1 ^ i_op2;
    assign o_or  = i_op1 | i_op2;
    assign o_and = i_op1 & i_op2;

    assign o_shl = i_op1 << i_shamt;

    // One right shifter serves both forms via the extra sign bit.
    assign shr_ext  = {i_arith & i_op1[XLEN-1], i_op1};
    assign shr_full = $signed(shr_ext) >>> i_shamt;
    assign o_shr    = shr_full[XLEN-1:0];

endmodule

//--- logic/exec_muldiv.sv
`timescale 1ns/1ps

module exec_muldiv
(
    input  logic                      i_clk,
    input  logic                      i_rst_n,
    input  logic                      i_start,
    input  logic                      i_abort,
    input  exec_pkg::exec_op_t        i_op,
    input  logic [exec_pkg::XLEN-1:0] i_op1,
    input  logic [exec_pkg::XLEN-1:0] i_op2,
    input  logic [exec_pkg::XLEN:0]   i_sum,
    output logic [exec_pkg::XLEN:0]   o_add_a,
    output logic [exec_pkg::XLEN:0]   o_add_b,
    output logic                      o_add_sub,
    output logic                      o_md_done,
    output logic [exec_pkg::XLEN-1:0] o_md_result
);
    import exec_pkg::*;

    localparam int CNT_W = $clog2(MD_ITERS);

    logic                is_div;
    logic                op1_signed;
    logic                op2_signed;
    logic                op1_neg;
    logic                op2_neg;
    logic [XLEN-1:0]     op1_mag;
    logic [XLEN-1:0]     op2_mag;
    logic [XLEN-1:0]     hi_q;
    logic [XLEN-1:0]     lo_q;
    logic [XLEN-1:0]     mcand_q;
    logic [CNT_W-1:0]    cnt_q;
    logic                busy_q;
    logic                fix_q;
    logic                div_fit;
    logic [2*XLEN-1:0]   prod;
    logic [2*XLEN-1:0]   prod_fix;
    logic [XLEN-1:0]     quot_fix;
    logic [XLEN-1:0]     rem_fix;
    logic                div_zero;
    logic                div_ovf;

    assign is_div     = i_op inside {OP_DIV, OP_DIVU, OP_REM, OP_REMU};
    assign op1_signed = i_op inside {OP_MULH, OP_MULHSU, OP_DIV, OP_REM};
    assign op2_signed = i_op inside {OP_MULH, OP_DIV, OP_REM};

    assign op1_neg = op1_signed & i_op1[XLEN-1];
    assign op2_neg = op2_signed & i_op2[XLEN-1];
    assign op1_mag = op1_neg ? -i_op1 : i_op1;
    assign op2_mag = op2_neg ? -i_op2 : i_op2;

    // Multiply adds the multiplicand to the high half, divide trial-subtracts the divisor.
    assign o_add_a   = is_div ? {hi_q, lo_q[XLEN-1]} : {1'b0, hi_q};
    assign o_add_b   = {1'b0, (is_div | lo_q[0]) ? mcand_q : {XLEN{1'b0}}};
    assign o_add_sub = is_div;
    assign div_fit   = ~i_sum[XLEN];

    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n || i_abort)
        begin
            busy_q <= 1'b0;
            fix_q  <= 1'b0;
            cnt_q  <= '0;
        end
        else if (i_start)
        begin
            busy_q <= 1'b1;
            fix_q  <= 1'b0;
            cnt_q  <= '0;
        end
        else if (busy_q)
        begin
            cnt_q <= cnt_q + 1'b1;
            if (cnt_q == CNT_W'(MD_ITERS - 1))
            begin
                busy_q <= 1'b0;
                fix_q  <= 1'b1; // Last step done, sign fix-up follows.
            end
        end
        else
            fix_q <= 1'b0;
    end

    always_ff @(posedge i_clk)
    begin
        if (i_start)
        begin
            hi_q    <= '0;
            lo_q    <= is_div ? op1_mag : op2_mag;
            mcand_q <= is_div ? op2_mag : op1_mag;
        end
        else if (busy_q && is_div)
        begin
            hi_q <= div_fit ? i_sum[XLEN-1:0] : {hi_q[XLEN-2:0], lo_q[XLEN-1]};
            lo_q <= {lo_q[XLEN-2:0], div_fit};
        end
        else if (busy_q)
        begin
            hi_q <= i_sum[XLEN:1];
            lo_q <= {i_sum[0], lo_q[XLEN-1:1]};
        end
    end

    assign prod     = {hi_q, lo_q};
    assign prod_fix = (op1_neg ^ op2_neg) ? -prod : prod;
    assign quot_fix = (op1_neg ^ op2_neg) ? -lo_q : lo_q;
    assign rem_fix  = op1_neg ? -hi_q : hi_q;   // Remainder takes the dividend's sign.

    assign div_zero = (i_op2 == '0);
    assign div_ovf  = op2_signed && (i_op1 == {1'b1, {(XLEN-1){1'b0}}}) && (i_op2 == '1);

    always_comb
    begin
        case (i_op)
            OP_MUL:            o_md_result = prod_fix[XLEN-1:0];
            OP_DIV, OP_DIVU:   o_md_result = div_zero ? '1 : (div_ovf ? i_op1 : quot_fix);
            OP_REM, OP_REMU:   o_md_result = div_zero ? i_op1 : (div_ovf ? '0 : rem_fix);
            default:           o_md_result = prod_fix[2*XLEN-1:XLEN];
        endcase
    end

    assign o_md_done = fix_q;

endmodule

//--- logic/exec_store_fmt.sv
`timescale 1ns/1ps

module exec_store_fmt
(
    input  exec_pkg::st_size_t        i_size,
    input  logic [1:0]                i_addr_lo,
    input  logic [exec_pkg::XLEN-1:0] i_data,
    output logic [exec_pkg::XLEN-1:0] o_wdata,
    output logic [3:0]                o_wsel
);
    import exec_pkg::*;

    always_comb
    begin
        case (i_size)
            ST_BYTE:
            begin
                o_wdata = {4{i_data[7:0]}};
                o_wsel  = 4'b0001 << i_addr_lo;
            end
            ST_HALF:
            begin
                o_wdata = {2{i_data[15:0]}};
                o_wsel  = 4'b0011 << {i_addr_lo[1], 1'b0}; // Half-word lanes are aligned.
            end
            ST_WORD:
            begin
                o_wdata = i_data;
                o_wsel  = 4'b1111;
            end
            default:
            begin
                o_wdata = i_data;
                o_wsel  = 4'b0000;
            end
        endcase
    end

endmodule

//--- logic/exec_stage.sv
`timescale 1ns/1ps

module exec_stage
(
    input  logic                      i_clk,
    input  logic                      i_rst_n,
    input  logic                      i_flush,
    input  logic                      i_valid,
    input  exec_pkg::exec_op_t        i_op,
    input  logic [exec_pkg::XLEN-1:0] i_op1,
    input  logic [exec_pkg::XLEN-1:0] i_op2,
    input  logic                      i_is_branch,
    input  logic                      i_is_jump,
    input  exec_pkg::br_cond_t        i_br_cond,
    input  logic [exec_pkg::PC_W-1:0] i_pc,
    input  logic [exec_pkg::PC_W-1:0] i_pc_target,
    input  logic                      i_is_store,
    input  exec_pkg::st_size_t        i_st_size,
    input  logic [exec_pkg::XLEN-1:0] i_store_data,
    output logic                      o_ready,
    output logic                      o_valid,
    output logic [exec_pkg::XLEN-1:0] o_result,
    output logic                      o_pc_select,
    output logic [exec_pkg::PC_W-1:0] o_pc_target,
    output logic [exec_pkg::XLEN-1:0] o_wdata,
    output logic [3:0]                o_wsel
);
    import exec_pkg::*;

    logic            valid_q;
    exec_op_t        op_q;
    logic [XLEN-1:0] op1_q;
    logic [XLEN-1:0] op2_q;
    logic            is_branch_q;
    logic            is_jump_q;
    br_cond_t        br_cond_q;
    logic [PC_W-1:0] pc_q;
    logic [PC_W-1:0] pc_target_q;
    logic            is_store_q;
    st_size_t        st_size_q;
    logic [XLEN-1:0] st_data_q;
    logic [XLEN-1:0] md_res_q;

    exec_state_t     state_q;
    exec_state_t     state_next;
    logic            is_md;
    logic            md_start;
    logic            md_sel;
    logic            alu_sub;

    logic [XLEN:0]   add_a;
    logic [XLEN:0]   add_b;
    logic            add_sub;
    logic [XLEN:0]   sum;
    logic            eq;
    logic            lts;
    logic            ltu;
    logic [XLEN:0]   md_add_a;
    logic [XLEN:0]   md_add_b;
    logic            md_add_sub;
    logic            md_done;
    logic [XLEN-1:0] md_result;

    logic [XLEN-1:0] xor_res;
    logic [XLEN-1:0] or_res;
    logic [XLEN-1:0] and_res;
    logic [XLEN-1:0] shl_res;
    logic [XLEN-1:0] shr_res;
    logic [XLEN-1:0] alu_res;
    logic [PC_W-1:0] link_addr;
    logic            br_taken;
    logic [XLEN-1:0] st_wdata;
    logic [3:0]      st_wsel;

    assign is_md = valid_q && !(is_branch_q || is_jump_q || is_store_q) &&
                   (op_q inside {OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU,
                                 OP_DIV, OP_DIVU, OP_REM, OP_REMU});
    assign md_start = (state_q == ST_IDLE) && is_md;
    assign md_sel   = (state_q == ST_ITER);

    // A new issue is taken in the result cycle of a multiply/divide.
    assign o_ready = (state_q == ST_DONE) || ((state_q == ST_IDLE) && !is_md);

    always_comb
    begin
        case (state_q)
            ST_IDLE: state_next = md_start ? ST_ITER : ST_IDLE;
            ST_ITER: state_next = md_done ? ST_DONE : ST_ITER;
            default: state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n || i_flush)
        begin
            state_q <= ST_IDLE;
            valid_q <= 1'b0;
        end
        else
        begin
            state_q <= state_next;
            if (o_ready)
                valid_q <= i_valid;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (o_ready)
        begin
            op_q        <= i_op;
            op1_q       <= i_op1;
            op2_q       <= i_op2;
            is_branch_q <= i_is_branch;
            is_jump_q   <= i_is_jump;
            br_cond_q   <= i_br_cond;
            pc_q        <= i_pc;
            pc_target_q <= i_pc_target;
            is_store_q  <= i_is_store;
            st_size_q   <= i_st_size;
            st_data_q   <= i_store_data;
        end
        if (md_done)
            md_res_q <= md_result;
    end

    assign alu_sub = !is_store_q && (is_branch_q || (op_q inside {OP_SUB, OP_SLT, OP_SLTU}));

    // The multiply/divide unit owns the adder while it iterates.
    assign add_a   = md_sel ? md_add_a : {1'b0, op1_q};
    assign add_b   = md_sel ? md_add_b : {1'b0, op2_q};
    assign add_sub = md_sel ? md_add_sub : alu_sub;

    exec_adder u_adder
    (
        .i_sub  (add_sub),
        .i_op1  (add_a),
        .i_op2  (add_b),
        .o_sum  (sum),
        .o_eq   (eq),
        .o_lts  (lts),
        .o_ltu  (ltu)
    );

    exec_shift_logic u_shift_logic
    (
        .i_op1   (op1_q),
        .i_op2   (op2_q),
        .i_shamt (op2_q[4:0]),
        .i_arith (op_q == OP_SRA),
        .o_xor   (xor_res),
        .o_or    (or_res),
        .o_and   (and_res),
        .o_shl   (shl_res),
        .o_shr   (shr_res)
    );

    exec_muldiv u_muldiv
    (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_start     (md_start),
        .i_abort     (i_flush),
        .i_op        (op_q),
        .i_op1       (op1_q),
        .i_op2       (op2_q),
        .i_sum       (sum),
        .o_add_a     (md_add_a),
        .o_add_b     (md_add_b),
        .o_add_sub   (md_add_sub),
        .o_md_done   (md_done),
        .o_md_result (md_result)
    );

    exec_store_fmt u_store_fmt
    (
        .i_size    (st_size_q),
        .i_addr_lo (sum[1:0]),
        .i_data    (st_data_q),
        .o_wdata   (st_wdata),
        .o_wsel    (st_wsel)
    );

    always_comb
    begin
        case (br_cond_q)
            BR_EQ:   br_taken = eq;
            BR_NE:   br_taken = !eq;
            BR_LT:   br_taken = lts;
            BR_GE:   br_taken = !lts;
            BR_LTU:  br_taken = ltu;
            BR_GEU:  br_taken = !ltu;
            default: br_taken = 1'b0;
        endcase
    end

    always_comb
    begin
        case (op_q)
            OP_ADD, OP_SUB: alu_res = sum[XLEN-1:0];
            OP_SLT:         alu_res = {{(XLEN-1){1'b0}}, lts};
            OP_SLTU:        alu_res = {{(XLEN-1){1'b0}}, ltu};
            OP_XOR:         alu_res = xor_res;
            OP_OR:          alu_res = or_res;
            OP_AND:         alu_res = and_res;
            OP_SLL:         alu_res = shl_res;
            OP_SRL, OP_SRA: alu_res = shr_res;
            default:        alu_res = md_res_q;
        endcase
    end

    assign link_addr = pc_q + PC_W'(4);

    assign o_valid     = valid_q && (!is_md || (state_q == ST_DONE));
    assign o_result    = is_jump_q ? XLEN'(link_addr) :
                         is_store_q ? sum[XLEN-1:0] : alu_res;
    assign o_pc_select = o_valid && (is_jump_q || (is_branch_q && br_taken));
    assign o_pc_target = pc_target_q;
    assign o_wdata     = st_wdata;
    assign o_wsel      = (o_valid && is_store_q) ? st_wsel : 4'b0000;

endmodule

//--- testbench/tb_exec_stage.sv
`timescale 1ns/1ps

module tb_exec_stage;
    import exec_pkg::*;

    logic            i_clk;
    logic            i_rst_n;
    logic            i_flush;
    logic            i_valid;
    exec_op_t        i_op;
    logic [XLEN-1:0] i_op1;
    logic [XLEN-1:0] i_op2;
    logic            i_is_branch;
    logic            i_is_jump;
    br_cond_t        i_br_cond;
    logic [PC_W-1:0] i_pc;
    logic [PC_W-1:0] i_pc_target;
    logic            i_is_store;
    st_size_t        i_st_size;
    logic [XLEN-1:0] i_store_data;
    logic            o_ready;
    logic            o_valid;
    logic [XLEN-1:0] o_result;
    logic            o_pc_select;
    logic [PC_W-1:0] o_pc_target;
    logic [XLEN-1:0] o_wdata;
    logic [3:0]      o_wsel;

    exec_stage exec_stage_inst
    (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_flush      (i_flush),
        .i_valid      (i_valid),
        .i_op         (i_op),
        .i_op1        (i_op1),
        .i_op2        (i_op2),
        .i_is_branch  (i_is_branch),
        .i_is_jump    (i_is_jump),
        .i_br_cond    (i_br_cond),
        .i_pc         (i_pc),
        .i_pc_target  (i_pc_target),
        .i_is_store   (i_is_store),
        .i_st_size    (i_st_size),
        .i_store_data (i_store_data),
        .o_ready      (o_ready),
        .o_valid      (o_valid),
        .o_result     (o_result),
        .o_pc_select  (o_pc_select),
        .o_pc_target  (o_pc_target),
        .o_wdata      (o_wdata),
        .o_wsel       (o_wsel)
    );

    initial
    begin
        i_clk = 1'b0;
        forever #4 i_clk = ~i_clk;
    end

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("tests failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        report_failure($sformatf("FAIL %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        assert (got === exp) else report_mismatch(name, got, exp);
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        assert (got === exp) else report_mismatch(name, {31'h0, got}, {31'h0, exp});
    endtask

    // Side flags never show up outside a result cycle, and a stalled stage has no result.
    assert property (@(posedge i_clk) disable iff (!i_rst_n)
                     (o_pc_select || (o_wsel != 4'b0000)) |-> o_valid)
        else report_failure("branch or store flag raised without o_valid");
    assert property (@(posedge i_clk) disable iff (!i_rst_n) !o_ready |-> !o_valid)
        else report_failure("o_valid raised while o_ready was low");

    task automatic tick;
        @(posedge i_clk);
        #1;
    endtask

    task automatic wait_ready;
        int n;
        n = 0;
        while (!o_ready)
        begin
            tick();
            n++;
            if (n > 100)
                report_failure("timed out waiting for o_ready");
        end
    endtask

    task automatic issue_op(input exec_op_t op, input logic [31:0] a, input logic [31:0] b);
        i_valid     = 1'b1;
        i_op        = op;
        i_op1       = a;
        i_op2       = b;
        i_is_branch = 1'b0;
        i_is_jump   = 1'b0;
        i_is_store  = 1'b0;
    endtask

    task automatic drive_idle;
        i_valid     = 1'b0;
        i_is_branch = 1'b0;
        i_is_jump   = 1'b0;
        i_is_store  = 1'b0;
    endtask

    function automatic logic [31:0] alu_model(input exec_op_t op, input logic [31:0] a,
                                              input logic [31:0] b);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_SLL:  return a << b[4:0];
            OP_SLT:  return {31'h0, $signed(a) < $signed(b)};
            OP_SLTU: return {31'h0, a < b};
            OP_XOR:  return a ^ b;
            OP_SRL:  return a >> b[4:0];
            OP_SRA:  return $signed(a) >>> b[4:0];
            OP_OR:   return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic [31:0] md_model(input exec_op_t op, input logic [31:0] a,
                                             input logic [31:0] b);
        logic signed [63:0] ss;
        logic signed [63:0] su;
        logic [63:0]        uu;
        logic signed [31:0] sq;
        logic signed [31:0] sr;
        ss = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
        su = $signed({{32{a[31]}}, a}) * $signed({32'h0, b});
        uu = {32'h0, a} * {32'h0, b};
        if (b == 32'h0)
        begin
            sq = '1; // Division by zero gives all ones and keeps the dividend.
            sr = a;
        end
        else if ((a == 32'h8000_0000) && (b == 32'hffff_ffff))
        begin
            sq = a;
            sr = '0;
        end
        else
        begin
            sq = $signed(a) / $signed(b);
            sr = $signed(a) % $signed(b);
        end
        case (op)
            OP_MUL:    return uu[31:0];
            OP_MULH:   return ss[63:32];
            OP_MULHSU: return su[63:32];
            OP_MULHU:  return uu[63:32];
            OP_DIV:    return sq;
            OP_REM:    return sr;
            OP_DIVU:   return (b == 32'h0) ? 32'hffff_ffff : a / b;
            default:   return (b == 32'h0) ? a : a % b;
        endcase
    endfunction

    function automatic logic br_model(input br_cond_t cond, input logic [31:0] a,
                                      input logic [31:0] b);
        case (cond)
            BR_EQ:   return a == b;
            BR_NE:   return a != b;
            BR_LT:   return $signed(a) < $signed(b);
            BR_GE:   return $signed(a) >= $signed(b);
            BR_LTU:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic run_alu_ops;
        exec_op_t    op;
        logic [31:0] a;
        logic [31:0] b;
        for (int i = 0; i < 200; i++)
        begin
            op = exec_op_t'(5'($urandom_range(9, 0)));
            a  = $urandom;
            b  = $urandom;
            check_bit("o_ready", o_ready, 1'b1);
            issue_op(op, a, b);
            tick();
            check_bit("o_valid", o_valid, 1'b1);
            check_word("o_result", o_result, alu_model(op, a, b));
            if ($urandom_range(3, 0) == 0)
            begin
                drive_idle();
                tick();
                check_bit("o_valid", o_valid, 1'b0);
            end
        end
        drive_idle();
        tick();
    endtask

    task automatic run_md_op(input exec_op_t op, input logic [31:0] a, input logic [31:0] b);
        logic [31:0] exp;
        int          edges;
        exp = md_model(op, a, b);
        wait_ready();
        issue_op(op, a, b);
        tick();
        drive_idle();
        edges = 0;
        while (!o_valid)
        begin
            check_bit("o_ready", o_ready, 1'b0);
            tick();
            edges++;
            if (edges > 100)
                report_failure("timed out waiting for a multiply/divide result");
        end
        check_word("md_latency", edges, 34);
        check_word("o_result", o_result, exp);
        check_bit("o_ready", o_ready, 1'b1);
        tick();
        check_bit("o_valid", o_valid, 1'b0); // The result is a single-cycle pulse.
    endtask

    task automatic run_branches;
        br_cond_t    conds [6] = '{BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU};
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] pc;
        logic [31:0] target;
        for (int i = 0; i < 60; i++)
        begin
            a      = $urandom;
            b      = ($urandom_range(3, 0) == 0) ? a : $urandom;
            pc     = $urandom & 32'hffff_fffc;
            target = $urandom & 32'hffff_fffc;
            wait_ready();
            issue_op(OP_ADD, a, b);
            i_pc        = pc;
            i_pc_target = target;
            i_br_cond   = conds[i % 6];
            i_is_branch = (i % 10) != 9;
            i_is_jump   = (i % 10) == 9;
            tick();
            check_bit("o_valid", o_valid, 1'b1);
            check_word("o_pc_target", o_pc_target, target);
            if (i_is_jump)
            begin
                check_bit("o_pc_select", o_pc_select, 1'b1);
                check_word("o_result", o_result, pc + 32'd4);
            end
            else
                check_bit("o_pc_select", o_pc_select, br_model(conds[i % 6], a, b));
        end
        drive_idle();
        tick();
    endtask

    task automatic run_stores;
        st_size_t    sizes [3] = '{ST_BYTE, ST_HALF, ST_WORD};
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] d;
        logic [31:0] wd;
        logic [3:0]  ws;
        for (int s = 0; s < 3; s++)
        begin
            for (int off = 0; off < 4; off++)
            begin
                a = {30'($urandom_range(32'h3fff_ffff, 0)), 2'(off)};
                b = $urandom & 32'hffff_fffc; // Offset comes from the base only.
                d = $urandom;
                case (sizes[s])
                    ST_BYTE:
                    begin
                        wd = {4{d[7:0]}};
                        ws = 4'b0001 << off;
                    end
                    ST_HALF:
                    begin
                        wd = {2{d[15:0]}};
                        ws = (off >= 2) ? 4'b1100 : 4'b0011;
                    end
                    default:
                    begin
                        wd = d;
                        ws = 4'b1111;
                    end
                endcase
                wait_ready();
                issue_op(OP_ADD, a, b);
                i_is_store   = 1'b1;
                i_st_size    = sizes[s];
                i_store_data = d;
                tick();
                check_bit("o_valid", o_valid, 1'b1);
                check_bit("o_pc_select", o_pc_select, 1'b0);
                check_word("o_result", o_result, a + b);
                check_word("o_wdata", o_wdata, wd);
                check_word("o_wsel", {28'h0, o_wsel}, {28'h0, ws});
            end
        end
        drive_idle();
        tick();
    endtask

    task automatic run_flush;
        wait_ready();
        issue_op(OP_DIV, $urandom, $urandom | 32'h1);
        tick();
        drive_idle();
        repeat (10)
        begin
            check_bit("o_valid", o_valid, 1'b0);
            tick();
        end
        i_flush = 1'b1;
        tick();
        i_flush = 1'b0;
        check_bit("o_ready", o_ready, 1'b1);
        repeat (40)
        begin
            check_bit("o_valid", o_valid, 1'b0);
            tick();
        end
    endtask

    initial
    begin
        exec_op_t md_ops [8] = '{OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU,
                                 OP_DIV, OP_DIVU, OP_REM, OP_REMU};
        void'($urandom(32'h52d36b55));
        i_rst_n      = 1'b0;
        i_flush      = 1'b0;
        i_op         = OP_ADD;
        i_op1        = '0;
        i_op2        = '0;
        i_br_cond    = BR_EQ;
        i_pc         = '0;
        i_pc_target  = '0;
        i_st_size    = ST_WORD;
        i_store_data = '0;
        drive_idle();
        repeat (8) @(posedge i_clk);
        #1;
        i_rst_n = 1'b1;
        check_bit("o_valid", o_valid, 1'b0);
        check_bit("o_ready", o_ready, 1'b1);
        check_bit("o_pc_select", o_pc_select, 1'b0);
        check_word("o_wsel", {28'h0, o_wsel}, 32'h0);

        run_alu_ops();
        for (int k = 0; k < 8; k++)
        begin
            run_md_op(md_ops[k], $urandom, 32'h0);
            run_md_op(md_ops[k], 32'h8000_0000, 32'hffff_ffff);
            run_md_op(md_ops[k], 32'hffff_fff9, 32'h0000_0002);
            run_md_op(md_ops[k], 32'h0000_0007, 32'hffff_fffe);
            repeat (4) run_md_op(md_ops[k], $urandom, $urandom);
            run_md_op(md_ops[k], $urandom, $urandom & 32'hff);
        end
        run_branches();
        run_stores();
        run_flush();
        run_alu_ops();

        $display("all tests passed");
        $finish;
    end

endmodule

//--- tb.f
logic/exec_pkg.sv
logic/exec_adder.sv
logic/exec_shift_logic.sv
logic/exec_muldiv.sv
logic/exec_store_fmt.sv
logic/exec_stage.sv
testbench/tb_exec_stage.sv

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it; a failing check exits non-zero.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_exec_stage \
    -f tb.f \
    -o tb_exec_stage

./obj_dir/tb_exec_stage
